/* bench/csr_vectors.txt */
# name ext sw tmr ill ecall ebreak mret funct3 index rs1 rnd imm pc minstret_inc ce check expected
# all fields hex, rnd=1 replaces rs1 with a random word
# check 0 none, 1 csr_out, 2 go_to_trap_q, 3 trap_address, 4 return_from_trap_q,
# 5 return_address, 6 mscratch model, 7 keep csr_out as mark, 8 csr_out minus mark
rst_mtvec      0 0 0 0 0 0 0 2 305 00000000 0 00 00000000 0 1 1 00000100
rst_misa       0 0 0 0 0 0 0 2 301 00000000 0 00 00000000 0 1 1 40000100
scr_write      0 0 0 0 0 0 0 1 340 00000000 1 00 00000000 0 1 0 00000000
scr_set        0 0 0 0 0 0 0 2 340 000000f0 0 00 00000000 0 1 6 00000000
scr_read       0 0 0 0 0 0 0 2 340 00000000 0 00 00000000 0 1 6 00000000
scr_clear      0 0 0 0 0 0 0 3 340 0f0f0000 0 00 00000000 0 1 6 00000000
scr_wi         0 0 0 0 0 0 0 5 340 00000000 0 15 00000000 0 1 6 00000000
scr_si         0 0 0 0 0 0 0 6 340 00000000 0 0a 00000000 0 1 6 00000000
scr_ci         0 0 0 0 0 0 0 7 340 00000000 0 03 00000000 0 1 6 00000000
scr_final      0 0 0 0 0 0 0 2 340 00000000 0 00 00000000 0 1 6 00000000
ecall_pulse    0 0 0 0 1 0 0 0 000 00000000 0 00 00002468 0 1 2 00000001
ecall_clear    0 0 0 0 0 0 0 0 000 00000000 0 00 0000246c 0 1 2 00000000
ecall_addr     0 0 0 0 0 0 0 0 000 00000000 0 00 00002470 0 1 3 00000100
ecall_mepc     0 0 0 0 0 0 0 2 341 00000000 0 00 00002474 0 1 1 00002468
ecall_mcause   0 0 0 0 0 0 0 2 342 00000000 0 00 00002478 0 1 1 0000000b
stall_illegal  0 0 0 1 0 0 0 0 000 00000000 0 00 0000247c 0 0 2 00000000
vec_mtvec      0 0 0 0 0 0 0 1 305 00000201 0 00 00003000 0 1 1 00000100
vec_mie        0 0 0 0 0 0 0 1 304 00000888 0 00 00003000 0 1 1 00000000
vec_mstatus    0 0 0 0 0 0 0 6 300 00000000 0 08 00003000 0 1 1 00001800
irq_assert     1 1 1 0 0 0 0 0 000 00000000 0 00 00003000 0 1 2 00000000
irq_take       1 1 1 0 0 0 0 0 000 00000000 0 00 00003000 0 1 2 00000001
irq_addr       0 0 0 0 0 0 0 0 000 00000000 0 00 00003004 0 0 3 0000022c
irq_mcause     0 0 0 0 0 0 0 2 342 00000000 0 00 00003008 0 1 1 8000000b
irq_mstatus    0 0 0 0 0 0 0 2 300 00000000 0 00 0000300c 0 1 1 00001880
mret_pulse     0 0 0 0 0 0 1 0 000 00000000 0 00 00003010 0 1 4 00000001
mret_addr      0 0 0 0 0 0 0 0 000 00000000 0 00 00003000 0 1 5 00003000
mret_mstatus   0 0 0 0 0 0 0 2 300 00000000 0 00 00003004 0 1 1 00001888
cnt_inhibit    0 0 0 0 0 0 0 5 320 00000000 0 05 00000000 0 1 1 00000000
cnt_minstret   0 0 0 0 0 0 0 1 b02 12345678 0 00 00000000 0 1 1 00000000
cnt_mcycle     0 0 0 0 0 0 0 1 b00 00004000 0 00 00000000 0 1 0 00000000
cnt_retire1    0 0 0 0 0 0 0 0 000 00000000 0 00 00000000 1 1 0 00000000
cnt_retire2    0 0 0 0 0 0 0 0 000 00000000 0 00 00000000 1 1 0 00000000
cnt_retire3    0 0 0 0 0 0 0 0 000 00000000 0 00 00000000 1 1 0 00000000
cnt_rd_instret 0 0 0 0 0 0 0 2 b02 00000000 0 00 00000000 1 1 1 12345678
cnt_rd_cycle   0 0 0 0 0 0 0 2 b00 00000000 0 00 00000000 1 1 1 00004000
cnt_uninhibit  0 0 0 0 0 0 0 7 320 00000000 0 01 00000000 0 1 1 00000005
cnt_mark       0 0 0 0 0 0 0 0 b00 00000000 0 00 00000000 0 1 7 00000000
cnt_wait1      0 0 0 0 0 0 0 0 b00 00000000 0 00 00000000 0 1 0 00000000
cnt_wait2      0 0 0 0 0 0 0 0 b00 00000000 0 00 00000000 0 1 0 00000000
cnt_wait3      0 0 0 0 0 0 0 0 b00 00000000 0 00 00000000 0 1 0 00000000
cnt_wait4      0 0 0 0 0 0 0 0 b00 00000000 0 00 00000000 0 1 0 00000000
cnt_delta      0 0 0 0 0 0 0 0 b00 00000000 0 00 00000000 0 1 8 00000005

/* verilog.f */
common/csr_pkg.sv
csr/csr_trap_bank.sv
csr/csr_counter_bank.sv
logic/csr_access.sv
logic/csr_unit.sv
bench/csr_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= csr_unit_tb
FILELIST  ?= verilog.f
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* bench/csr_unit_tb.sv */
// self-checking testbench for csr_unit that replays bench/csr_vectors.txt one step per clock
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;
  import csr_pkg::*;

  localparam int    CLK_PERIOD = 20;
  localparam string VEC_FILE   = "bench/csr_vectors.txt";

  logic      clk, rst_n;
  logic      ext_irq, sw_irq, tmr_irq;
  logic      illegal, ecall, ebreak, mret;
  funct3_t   funct3;
  csr_addr_t csr_index;
  xlen_t     imm, rs1, pc;
  logic      minstret_inc, ce;
  xlen_t     csr_out, trap_address, return_address;
  logic      go_to_trap_q, return_from_trap_q;

  string     vec_q[$];       // vector lines without comments
  bit        vec_opened;     // vector file could be read
  bit        vec_loaded;     // starts the watchdog
  int        n_pass, n_fail;
  xlen_t     scratch_model;  // expected mscratch contents
  xlen_t     mark;           // counter value kept for a delta check

  csr_unit #(
    .TRAP_ADDRESS (32'h0000_0100)
  ) dut0 (
    .i_clk                (clk),
    .i_rst_n              (rst_n),
    .i_external_interrupt (ext_irq),
    .i_software_interrupt (sw_irq),
    .i_timer_interrupt    (tmr_irq),
    .i_is_inst_illegal    (illegal),
    .i_is_ecall           (ecall),
    .i_is_ebreak          (ebreak),
    .i_is_mret            (mret),
    .i_funct3             (funct3),
    .i_csr_index          (csr_index),
    .i_imm                (imm),
    .i_rs1                (rs1),
    .i_pc                 (pc),
    .i_minstret_inc       (minstret_inc),
    .i_ce                 (ce),
    .o_csr_out            (csr_out),
    .o_trap_address       (trap_address),
    .o_return_address     (return_address),
    .o_go_to_trap_q       (go_to_trap_q),
    .o_return_from_trap_q (return_from_trap_q)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // funct3 bit 2 picks uimm and the low bits pick write, set or clear
  function automatic xlen_t zicsr_update(funct3_t op, xlen_t old, xlen_t src_reg,
                                         xlen_t src_imm);
    xlen_t src;
    src = op[2] ? src_imm : src_reg;
    case (op[1:0])
      2'b01:   return src;
      2'b10:   return old | src;
      2'b11:   return old & ~src;
      default: return old;
    endcase
  endfunction

  task automatic compare_value(input string name, input xlen_t expected, input xlen_t actual,
                               output bit ok);
    ok = (actual === expected);
    if (!ok) $display("FAILED %s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic load_vectors(output bit opened);
    int    fd;
    string line;
    fd = $fopen(VEC_FILE, "r");
    opened = (fd != 0);
    if (opened) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != 8'h23) vec_q.push_back(line);  // 8'h23 is '#'
      end
      $fclose(fd);
    end
  endtask

  // drives one vector on the falling edge and checks it after exactly one rising edge
  task automatic run_step(input string line);
    string name;
    int    n;
    bit    ok;
    xlen_t old_scratch;
    xlen_t v_ext, v_sw, v_tmr, v_ill, v_ecall, v_ebreak, v_mret;
    xlen_t v_f3, v_idx, v_rs1, v_rnd, v_imm, v_pc, v_inc, v_ce, v_sel, v_exp;
    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                v_ext, v_sw, v_tmr, v_ill, v_ecall, v_ebreak, v_mret, v_f3, v_idx,
                v_rs1, v_rnd, v_imm, v_pc, v_inc, v_ce, v_sel, v_exp);
    if (n != 18) begin
      $display("vector line could not be parsed: %s", line);
      n_fail++;
    end else begin
      if (v_rnd[0]) v_rs1 = $urandom();  // random scratch data
      @(negedge clk);
      ext_irq      = v_ext[0];
      sw_irq       = v_sw[0];
      tmr_irq      = v_tmr[0];
      illegal      = v_ill[0];
      ecall        = v_ecall[0];
      ebreak       = v_ebreak[0];
      mret         = v_mret[0];
      funct3       = v_f3[2:0];
      csr_index    = v_idx[11:0];
      rs1          = v_rs1;
      imm          = v_imm;
      pc           = v_pc;
      minstret_inc = v_inc[0];
      ce           = v_ce[0];
      old_scratch  = scratch_model;  // csr_out returns the value before the write
      if (v_ce[0] && v_f3[2:0] != 3'b000 && v_idx[11:0] == CSR_MSCRATCH)
        scratch_model = zicsr_update(v_f3[2:0], scratch_model, v_rs1, v_imm);
      @(posedge clk);
      #(CLK_PERIOD / 2 - 1);  // just before the next falling edge
      ok = 1'b1;
      case (v_sel)
        0: ok = 1'b1;  // setup step
        1: compare_value(name, v_exp, csr_out, ok);
        2: compare_value(name, v_exp, xlen_t'(go_to_trap_q), ok);
        3: compare_value(name, v_exp, trap_address, ok);
        4: compare_value(name, v_exp, xlen_t'(return_from_trap_q), ok);
        5: compare_value(name, v_exp, return_address, ok);
        6: compare_value(name, old_scratch, csr_out, ok);
        7: mark = csr_out;
        8: compare_value(name, v_exp, csr_out - mark, ok);
        default: begin
          $display("%s uses an unknown check selector %0d", name, v_sel);
          ok = 1'b0;
        end
      endcase
      if (ok) n_pass++;
      else n_fail++;
      $display("%s: %s", name, ok ? "ok" : "mismatch");
    end
  endtask

  // watchdog scaled by the number of vectors
  initial begin
    wait (vec_loaded);
    #((vec_q.size() + 4) * CLK_PERIOD * 4);
    abort_run("watchdog expired before all vectors were applied");
  end

  initial begin
    void'($urandom(32'h3b47_c82c));  // fixed seed
    rst_n        = 1'b0;
    ext_irq      = 1'b0;
    sw_irq       = 1'b0;
    tmr_irq      = 1'b0;
    illegal      = 1'b0;
    ecall        = 1'b0;
    ebreak       = 1'b0;
    mret         = 1'b0;
    funct3       = '0;
    csr_index    = '0;
    imm          = '0;
    rs1          = '0;
    pc           = '0;
    minstret_inc = 1'b0;
    ce           = 1'b0;
    n_pass        = 0;
    n_fail        = 0;
    scratch_model = '0;
    mark          = '0;
    load_vectors(vec_opened);
    if (!vec_opened) begin
      abort_run({"could not open the vector file ", VEC_FILE});
    end else begin
      vec_loaded = 1'b1;
      repeat (4) @(negedge clk);  // four rising edges in reset
      rst_n = 1'b1;
      foreach (vec_q[i]) run_step(vec_q[i]);
      $display("%0d tests run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
      if (n_fail == 0 && vec_q.size() > 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* logic/csr_unit.sv */
// top of the machine-mode csr unit, connects the trap bank, the counter bank and the access block
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
  parameter csr_pkg::xlen_t TRAP_ADDRESS = '0  // mtvec after reset
) (
  input  wire                     i_clk,
  input  wire                     i_rst_n,
  input  wire                     i_external_interrupt,
  input  wire                     i_software_interrupt,
  input  wire                     i_timer_interrupt,
  input  wire                     i_is_inst_illegal,
  input  wire                     i_is_ecall,
  input  wire                     i_is_ebreak,
  input  wire                     i_is_mret,
  input  wire csr_pkg::funct3_t   i_funct3,
  input  wire csr_pkg::csr_addr_t i_csr_index,
  input  wire csr_pkg::xlen_t     i_imm,
  input  wire csr_pkg::xlen_t     i_rs1,
  input  wire csr_pkg::xlen_t     i_pc,
  input  wire                     i_minstret_inc,
  input  wire                     i_ce,
  output csr_pkg::xlen_t          o_csr_out,
  output csr_pkg::xlen_t          o_trap_address,
  output csr_pkg::xlen_t          o_return_address,
  output logic                    o_go_to_trap_q,
  output logic                    o_return_from_trap_q
);
  import csr_pkg::*;

  logic  csr_wr;
  xlen_t csr_wdata;
  xlen_t trap_rdata, counter_rdata;

  csr_trap_bank #(
    .TRAP_ADDRESS (TRAP_ADDRESS)
  ) u_trap_bank (
    .i_clk                (i_clk),
    .i_rst_n              (i_rst_n),
    .i_external_interrupt (i_external_interrupt),
    .i_software_interrupt (i_software_interrupt),
    .i_timer_interrupt    (i_timer_interrupt),
    .i_is_inst_illegal    (i_is_inst_illegal),
    .i_is_ecall           (i_is_ecall),
    .i_is_ebreak          (i_is_ebreak),
    .i_is_mret            (i_is_mret),
    .i_ce                 (i_ce),
    .i_pc                 (i_pc),
    .i_csr_index          (i_csr_index),
    .i_csr_wr             (csr_wr),
    .i_csr_wdata          (csr_wdata),
    .o_rdata              (trap_rdata),
    .o_go_to_trap_q       (o_go_to_trap_q),
    .o_return_from_trap_q (o_return_from_trap_q),
    .o_trap_address       (o_trap_address),
    .o_return_address     (o_return_address)
  );

  // pulses feed back so trap and return cycles do not count as retired
  csr_counter_bank u_counter_bank (
    .i_clk                (i_clk),
    .i_rst_n              (i_rst_n),
    .i_csr_index          (i_csr_index),
    .i_csr_wr             (csr_wr),
    .i_csr_wdata          (csr_wdata),
    .i_minstret_inc       (i_minstret_inc),
    .i_go_to_trap_q       (o_go_to_trap_q),
    .i_return_from_trap_q (o_return_from_trap_q),
    .o_rdata              (counter_rdata)
  );

  csr_access u_access (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_ce            (i_ce),
    .i_funct3        (i_funct3),
    .i_imm           (i_imm),
    .i_rs1           (i_rs1),
    .i_trap_rdata    (trap_rdata),
    .i_counter_rdata (counter_rdata),
    .o_csr_wr        (csr_wr),
    .o_csr_wdata     (csr_wdata),
    .o_csr_out       (o_csr_out)
  );

endmodule

`default_nettype wire

/* logic/csr_access.sv */
// csr access path: merges bank read data, forms the zicsr write value and registers the old value
`timescale 1ns/1ps
`default_nettype none

module csr_access (
  input  wire                  i_clk,
  input  wire                  i_rst_n,
  input  wire                  i_ce,             // stage clock enable
  input  wire csr_pkg::funct3_t i_funct3,        // nonzero only for csr instructions
  input  wire csr_pkg::xlen_t  i_imm,            // zero-extended uimm
  input  wire csr_pkg::xlen_t  i_rs1,
  input  wire csr_pkg::xlen_t  i_trap_rdata,
  input  wire csr_pkg::xlen_t  i_counter_rdata,
  output logic                 o_csr_wr,         // write strobe to both banks
  output csr_pkg::xlen_t       o_csr_wdata,
  output csr_pkg::xlen_t       o_csr_out         // old csr value for the register file
);
  import csr_pkg::*;

  xlen_t csr_rdata;

  // foreign banks return zero, so an or is the mux
  assign csr_rdata = i_trap_rdata | i_counter_rdata;

  assign o_csr_wr = i_ce && (i_funct3 != 3'b000);

  always_comb begin
    case (i_funct3)
      OP_CSRRW:  o_csr_wdata = i_rs1;
      OP_CSRRS:  o_csr_wdata = csr_rdata | i_rs1;   // set bits
      OP_CSRRC:  o_csr_wdata = csr_rdata & ~i_rs1;  // clear bits
      OP_CSRRWI: o_csr_wdata = i_imm;
      OP_CSRRSI: o_csr_wdata = csr_rdata | i_imm;
      OP_CSRRCI: o_csr_wdata = csr_rdata & ~i_imm;
      default:   o_csr_wdata = csr_rdata;           // no change
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_csr_out <= '0;
    end else if (i_ce) begin
      o_csr_out <= csr_rdata;  // holds while stalled
    end
  end

endmodule

`default_nettype wire

/* csr/csr_counter_bank.sv */
// machine counters mcycle and minstret with mcountinhibit, read and written in 32-bit halves
`timescale 1ns/1ps
`default_nettype none

module csr_counter_bank (
  input  wire                     i_clk,
  input  wire                     i_rst_n,
  input  wire csr_pkg::csr_addr_t i_csr_index,
  input  wire                     i_csr_wr,
  input  wire csr_pkg::xlen_t     i_csr_wdata,
  input  wire                     i_minstret_inc,       // an instruction retires this cycle
  input  wire                     i_go_to_trap_q,
  input  wire                     i_return_from_trap_q,
  output csr_pkg::xlen_t          o_rdata               // zero unless the index is ours
);
  import csr_pkg::*;

  counter_t mcycle, minstret;
  logic     inhibit_cy, inhibit_ir;  // mcountinhibit bits 0 and 2

  wire wr_mcycle    = i_csr_wr && (i_csr_index == CSR_MCYCLE);
  wire wr_mcycleh   = i_csr_wr && (i_csr_index == CSR_MCYCLEH);
  wire wr_minstret  = i_csr_wr && (i_csr_index == CSR_MINSTRET);
  wire wr_minstreth = i_csr_wr && (i_csr_index == CSR_MINSTRETH);
  wire wr_inhibit   = i_csr_wr && (i_csr_index == CSR_MCOUNTINHIBIT);

  // trap and return cycles retire nothing
  wire instret_step = i_minstret_inc && !i_go_to_trap_q && !i_return_from_trap_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mcycle     <= '0;
      minstret   <= '0;
      inhibit_cy <= 1'b0;
      inhibit_ir <= 1'b0;
    end else begin
      if (wr_mcycle)        mcycle <= {mcycle[63:32], i_csr_wdata};  // write beats increment
      else if (wr_mcycleh)  mcycle <= {i_csr_wdata, mcycle[31:0]};
      else if (!inhibit_cy) mcycle <= mcycle + 64'd1;                // runs regardless of i_ce

      if (wr_minstret)       minstret <= {minstret[63:32], i_csr_wdata};
      else if (wr_minstreth) minstret <= {i_csr_wdata, minstret[31:0]};
      else if (!inhibit_ir && instret_step) minstret <= minstret + 64'd1;

      if (wr_inhibit) begin
        inhibit_cy <= i_csr_wdata[0];
        inhibit_ir <= i_csr_wdata[2];
      end
    end
  end

  always_comb begin
    case (i_csr_index)
      CSR_MCYCLE:        o_rdata = mcycle[31:0];
      CSR_MCYCLEH:       o_rdata = mcycle[63:32];
      CSR_MINSTRET:      o_rdata = minstret[31:0];
      CSR_MINSTRETH:     o_rdata = minstret[63:32];
      CSR_MCOUNTINHIBIT: o_rdata = {29'd0, inhibit_ir, 1'b0, inhibit_cy};
      default:           o_rdata = '0;
    endcase
  end

  // inhibited and unwritten counters freeze
  a_cycle_inhibit_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (inhibit_cy && !wr_mcycle && !wr_mcycleh) |=> $stable(mcycle));

  a_instret_inhibit_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (inhibit_ir && !wr_minstret && !wr_minstreth) |=> $stable(minstret));

endmodule

`default_nettype wire

/* csr/csr_trap_bank.sv */
// trap csrs of the machine-mode unit: interrupt and exception detection, trap entry and mret
`timescale 1ns/1ps
`default_nettype none

module csr_trap_bank #(
  parameter csr_pkg::xlen_t TRAP_ADDRESS = '0  // reset value of mtvec
) (
  input  wire                 i_clk,
  input  wire                 i_rst_n,
  input  wire                 i_external_interrupt,
  input  wire                 i_software_interrupt,
  input  wire                 i_timer_interrupt,
  input  wire                 i_is_inst_illegal,
  input  wire                 i_is_ecall,
  input  wire                 i_is_ebreak,
  input  wire                 i_is_mret,
  input  wire                 i_ce,                  // stage clock enable
  input  wire csr_pkg::xlen_t    i_pc,
  input  wire csr_pkg::csr_addr_t i_csr_index,
  input  wire                 i_csr_wr,              // write strobe from the access block
  input  wire csr_pkg::xlen_t    i_csr_wdata,
  output csr_pkg::xlen_t      o_rdata,               // zero unless the index is ours
  output logic                o_go_to_trap_q,
  output logic                o_return_from_trap_q,
  output csr_pkg::xlen_t      o_trap_address,
  output csr_pkg::xlen_t      o_return_address
);
  import csr_pkg::*;

  localparam logic [1:0] MPP_MACHINE = 2'b11;  // only machine mode exists

  logic        mstatus_mie, mstatus_mpie;
  logic        mie_meie, mie_mtie, mie_msie;
  logic        mip_meip, mip_mtip, mip_msip;
  logic [29:0] mtvec_base;
  logic [1:0]  mtvec_mode;  // 1 = vectored
  xlen_t       mscratch, mepc, mtval;
  logic        mcause_intr;
  cause_code_t mcause_code;

  logic        ext_pend, sw_pend, tmr_pend;
  logic        is_interrupt, trap_take, mret_take;
  cause_code_t trap_cause;
  xlen_t       trap_target;

  // per-register write enables
  wire wr_mstatus  = i_csr_wr && (i_csr_index == CSR_MSTATUS);
  wire wr_mie      = i_csr_wr && (i_csr_index == CSR_MIE);
  wire wr_mtvec    = i_csr_wr && (i_csr_index == CSR_MTVEC);
  wire wr_mscratch = i_csr_wr && (i_csr_index == CSR_MSCRATCH);
  wire wr_mepc     = i_csr_wr && (i_csr_index == CSR_MEPC);
  wire wr_mcause   = i_csr_wr && (i_csr_index == CSR_MCAUSE);
  wire wr_mtval    = i_csr_wr && (i_csr_index == CSR_MTVAL);

  // pending and enabled, all gated by the global mie
  assign ext_pend     = mstatus_mie && mie_meie && mip_meip;
  assign sw_pend      = mstatus_mie && mie_msie && mip_msip;
  assign tmr_pend     = mstatus_mie && mie_mtie && mip_mtip;
  assign is_interrupt = ext_pend || sw_pend || tmr_pend;

  // one entry per pulse, a held trap condition does not re-enter
  assign trap_take = i_ce && !o_go_to_trap_q &&
                     (is_interrupt || i_is_inst_illegal || i_is_ecall || i_is_ebreak);
  assign mret_take = i_ce && i_is_mret && !trap_take;  // trap wins over mret

  always_comb begin  // fixed priority: interrupts first, then exceptions
    if (ext_pend)               trap_cause = CAUSE_M_EXTERNAL;
    else if (sw_pend)           trap_cause = CAUSE_M_SOFTWARE;
    else if (tmr_pend)          trap_cause = CAUSE_M_TIMER;
    else if (i_is_inst_illegal) trap_cause = CAUSE_ILLEGAL;
    else if (i_is_ecall)        trap_cause = CAUSE_ECALL;
    else                        trap_cause = CAUSE_EBREAK;
  end

  // vectored mode offsets interrupts by 4 * cause
  assign trap_target = (mtvec_mode == 2'b01 && is_interrupt) ?
                       {mtvec_base, 2'b00} + xlen_t'({trap_cause, 2'b00}) :
                       {mtvec_base, 2'b00};

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mie_meie     <= 1'b0;
      mie_mtie     <= 1'b0;
      mie_msie     <= 1'b0;
      mip_meip     <= 1'b0;
      mip_mtip     <= 1'b0;
      mip_msip     <= 1'b0;
      mtvec_base   <= TRAP_ADDRESS[31:2];
      mtvec_mode   <= TRAP_ADDRESS[1:0];
      mcause_intr  <= 1'b0;
      mcause_code  <= '0;
      o_go_to_trap_q       <= 1'b0;
      o_return_from_trap_q <= 1'b0;
      o_trap_address       <= '0;
      o_return_address     <= '0;
    end else begin
      mip_meip <= i_external_interrupt;  // sampled every clock
      mip_mtip <= i_timer_interrupt;
      mip_msip <= i_software_interrupt;

      if (wr_mstatus) begin  // an explicit write beats trap stacking
        mstatus_mie  <= i_csr_wdata[3];
        mstatus_mpie <= i_csr_wdata[7];
      end else if (trap_take) begin
        mstatus_mpie <= mstatus_mie;
        mstatus_mie  <= 1'b0;  // no nesting
      end else if (mret_take) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
      end

      if (wr_mie) begin
        mie_msie <= i_csr_wdata[3];
        mie_mtie <= i_csr_wdata[7];
        mie_meie <= i_csr_wdata[11];
      end

      if (wr_mtvec) begin
        mtvec_base <= i_csr_wdata[31:2];
        mtvec_mode <= i_csr_wdata[1:0];
      end

      if (trap_take) begin
        mcause_intr <= is_interrupt;
        mcause_code <= trap_cause;
      end else if (wr_mcause) begin
        mcause_intr <= i_csr_wdata[31];
        mcause_code <= i_csr_wdata[3:0];
      end

      if (i_ce) begin
        o_go_to_trap_q       <= trap_take;
        o_return_from_trap_q <= mret_take;
        o_trap_address       <= trap_target;
        o_return_address     <= mepc;
      end else begin  // stalled stage drops both pulses
        o_go_to_trap_q       <= 1'b0;
        o_return_from_trap_q <= 1'b0;
      end
    end
  end

  // payload registers
  always_ff @(posedge i_clk) begin
    if (wr_mscratch) mscratch <= i_csr_wdata;
    if (wr_mtval)    mtval    <= i_csr_wdata;
    if (trap_take)   mepc     <= i_pc;  // trap entry beats a software write
    else if (wr_mepc) mepc    <= {i_csr_wdata[31:2], 2'b00};
  end

  always_comb begin
    o_rdata = '0;
    case (i_csr_index)
      CSR_MSTATUS: begin
        o_rdata[3]     = mstatus_mie;
        o_rdata[7]     = mstatus_mpie;
        o_rdata[12:11] = MPP_MACHINE;
      end
      CSR_MISA:     o_rdata = MISA_VALUE;
      CSR_MIE:      o_rdata = xlen_t'({mie_meie, 3'b000, mie_mtie, 3'b000, mie_msie, 3'b000});
      CSR_MIP:      o_rdata = xlen_t'({mip_meip, 3'b000, mip_mtip, 3'b000, mip_msip, 3'b000});
      CSR_MTVEC:    o_rdata = {mtvec_base, mtvec_mode};
      CSR_MSCRATCH: o_rdata = mscratch;
      CSR_MEPC:     o_rdata = mepc;
      CSR_MCAUSE:   o_rdata = {mcause_intr, 27'd0, mcause_code};
      CSR_MTVAL:    o_rdata = mtval;
      default:      o_rdata = '0;  // id registers and foreign indices read zero
    endcase
  end

  // trap wins over mret, so the two pulses stay exclusive
  a_pulses_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_go_to_trap_q && o_return_from_trap_q));

  a_trap_single_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_go_to_trap_q && i_ce) |=> !o_go_to_trap_q);

endmodule

`default_nettype wire

/* common/csr_pkg.sv */
// shared types and encodings for the machine-mode csr unit, imported by every rtl block
`default_nettype none

package csr_pkg;

  // data and field widths
  typedef logic [31:0] xlen_t;        // csr data, pc, rs1 and imm
  typedef logic [11:0] csr_addr_t;    // csr index from the instruction
  typedef logic [2:0]  funct3_t;      // csr operation field
  typedef logic [3:0]  cause_code_t;  // mcause exception code
  typedef logic [63:0] counter_t;     // mcycle and minstret are 64 bits by the spec

  // machine info, all read as zero
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  // machine trap setup
  localparam csr_addr_t CSR_MSTATUS       = 12'h300;
  localparam csr_addr_t CSR_MISA          = 12'h301;
  localparam csr_addr_t CSR_MIE           = 12'h304;
  localparam csr_addr_t CSR_MTVEC         = 12'h305;
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;

  // machine trap handling
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;
  localparam csr_addr_t CSR_MIP      = 12'h344;

  // machine counters, low and high halves
  localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
  localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH = 12'hB82;

  // funct3 of the zicsr instructions, zero means no csr access
  localparam funct3_t OP_CSRRW  = 3'b001;
  localparam funct3_t OP_CSRRS  = 3'b010;
  localparam funct3_t OP_CSRRC  = 3'b011;
  localparam funct3_t OP_CSRRWI = 3'b101;
  localparam funct3_t OP_CSRRSI = 3'b110;
  localparam funct3_t OP_CSRRCI = 3'b111;

  // interrupt causes, mcause bit 31 set
  localparam cause_code_t CAUSE_M_SOFTWARE = 4'd3;
  localparam cause_code_t CAUSE_M_TIMER    = 4'd7;
  localparam cause_code_t CAUSE_M_EXTERNAL = 4'd11;

  // synchronous exception causes, mcause bit 31 clear
  localparam cause_code_t CAUSE_ILLEGAL = 4'd2;
  localparam cause_code_t CAUSE_EBREAK  = 4'd3;
  localparam cause_code_t CAUSE_ECALL   = 4'd11;

  // rv32 base (mxl = 1) with the i extension
  localparam xlen_t MISA_VALUE = 32'h4000_0100;

endpackage

`default_nettype wire
